// File: Makefile
# Verilator build and run of the fetch testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: dv/tb_fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_top;

	import icache_pkg::*;

	localparam logic [31:0] SEED          = 32'h2a5c;
	localparam int          RUN_CYCLES    = 2000;
	localparam int          RESET_CYCLES  = 8;
	localparam int          FIRST_TIMEOUT = 8;

	logic                  clk;
	logic                  rst;
	logic [ADDR_W-1:0]     addr;
	logic                  valid;
	logic                  flush;
	logic                  ready_if_id;
	logic                  prog_we;
	logic [MEM_ADDR_W-1:0] prog_addr;
	logic [LINE_W-1:0]     prog_data;
	logic [INST_W-1:0]     inst;
	logic                  ready;
	logic                  hit;

	// reference model of memory, tags and the response slot
	logic [LINE_W-1:0] m_mem [MEM_LINES];
	logic [TAG_W-1:0]  m_tag [NUM_WAYS][NUM_SETS];
	logic              m_vld [NUM_WAYS][NUM_SETS];
	int                m_victim;
	logic              model_live = 1'b0;
	logic              exp_ready;
	logic              exp_hit;
	logic [INST_W-1:0] exp_inst;
	logic              exp_hold = 1'b0;    // last edge was a stall
	logic [INST_W-1:0] last_inst;

	logic [31:0] lfsr;
	logic        first_ok;
	int          n_checks = 0;
	int          n_errors = 0;

	fetch_top i_fetch_top (
		.clk         (clk),
		.rst         (rst),
		.addr        (addr),
		.valid       (valid),
		.flush       (flush),
		.ready_if_id (ready_if_id),
		.prog_we     (prog_we),
		.prog_addr   (prog_addr),
		.prog_data   (prog_data),
		.inst        (inst),
		.ready       (ready),
		.hit         (hit)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	// --------------------------------------------------
	// model
	// --------------------------------------------------
	function automatic int model_lookup(input logic [ADDR_W-1:0] a);
		int way;
		way = -1;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (m_vld[w][a[9:4]] && m_tag[w][a[9:4]] == a[31:10]) begin
				way = w;
			end
		end
		return way;
	endfunction

	function automatic logic [INST_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
		logic [LINE_W-1:0] line;
		line = m_mem[a[13:4]];                 // bits above 13 ignored
		return line[a[3:2]*32 +: 32];
	endfunction

	task automatic model_edge();
		int way;
		way = -1;
		if (prog_we) begin
			m_mem[prog_addr] = prog_data;
		end
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				for (int s = 0; s < NUM_SETS; s++) begin
					m_vld[w][s] = 1'b0;
				end
			end
			m_victim   = 0;
			exp_ready  = 1'b0;
			exp_hit    = 1'b0;
			exp_hold   = 1'b0;
			model_live = 1'b1;
		end else if (!ready_if_id) begin
			exp_hold = 1'b1;                   // frozen
		end else begin
			exp_hold = 1'b0;
			if (valid) begin
				way = model_lookup(addr);
			end
			if (valid && way < 0) begin        // fill even under flush
				m_tag[m_victim][addr[9:4]] = addr[31:10];
				m_vld[m_victim][addr[9:4]] = 1'b1;
			end
			if (flush) begin
				exp_ready = 1'b0;
				exp_hit   = 1'b0;
			end else begin
				exp_ready = valid;
				exp_hit   = valid && way >= 0;
				if (valid) begin
					exp_inst = mem_word(addr);
				end
				m_victim = (m_victim + 1) % NUM_WAYS;
			end
		end
	endtask

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	task automatic report_mismatch(input string name, input logic [31:0] e,
		input logic [31:0] a);
		n_errors++;
		$display("mismatch at %0t: %s expected %h, got %h", $time, name, e, a);
	endtask

	task automatic check_outputs();
		n_checks++;
		if (ready !== exp_ready) begin
			report_mismatch("ready", 32'(exp_ready), 32'(ready));
		end
		if (hit !== exp_hit) begin
			report_mismatch("hit", 32'(exp_hit), 32'(hit));
		end
		if (exp_ready && inst !== exp_inst) begin
			report_mismatch("inst", exp_inst, inst);
		end
		if (exp_hold && inst !== last_inst) begin
			report_mismatch("inst (stalled)", last_inst, inst);
		end
		last_inst = inst;
	endtask

	always @(posedge clk) begin
		model_edge();
	end

	always @(negedge clk) begin
		if (model_live) begin
			check_outputs();
		end
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	task automatic preload_memory();
		for (int i = 0; i < MEM_LINES; i++) begin
			prog_we   <= 1'b1;
			prog_addr <= MEM_ADDR_W'(i);
			prog_data <= {take_bits(32), take_bits(32), take_bits(32), take_bits(32)};
			@(posedge clk);
		end
		prog_we <= 1'b0;
	endtask

	task automatic first_fetch(output logic answered);
		int waited;
		waited = 0;
		addr  <= 32'h0000_0044;
		valid <= 1'b1;
		@(posedge clk);
		valid <= 1'b0;
		@(negedge clk);
		while (ready !== 1'b1 && waited < FIRST_TIMEOUT) begin
			waited++;
			@(negedge clk);
		end
		answered = (ready === 1'b1);
		if (!answered) begin
			n_errors++;
			$display("timeout: no response to the first fetch after %0d cycles", waited);
		end
		@(posedge clk);
	endtask

	// few tags over 8 sets, so lines get evicted
	task automatic random_fetches();
		logic [18:0] tag_hi;
		logic [2:0]  tag_lo;
		logic [5:0]  index;
		logic [1:0]  word;
		for (int c = 0; c < RUN_CYCLES; c++) begin
			tag_hi = (take_bits(4) == 0) ? 19'(take_bits(19)) : '0;
			tag_lo = 3'(take_bits(3));
			index  = {3'b000, 3'(take_bits(3))};
			word   = 2'(take_bits(2));
			addr        <= {tag_hi, tag_lo, index, word, 2'b00};
			valid       <= take_bits(5) < 26;  // about 80%
			ready_if_id <= take_bits(5) >= 5;  // low about 15%
			flush       <= take_bits(5) < 2;   // about 5%
			@(posedge clk);
		end
		valid       <= 1'b0;
		flush       <= 1'b0;
		ready_if_id <= 1'b1;
	endtask

	initial begin
		lfsr        = SEED;
		rst         <= 1'b1;
		addr        <= '0;
		valid       <= 1'b0;
		flush       <= 1'b0;
		ready_if_id <= 1'b1;
		prog_we     <= 1'b0;
		prog_addr   <= '0;
		prog_data   <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		preload_memory();
		first_fetch(first_ok);
		if (first_ok) begin
			random_fetches();
			repeat (2) @(posedge clk);
		end
		$display("errors %0d in %0d checks", n_errors, n_checks);
		if (n_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
rtl/icache_pkg.sv
rtl/icache_tag_store.sv
rtl/icache_data_sram.sv
rtl/icache.sv
rtl/inst_mem.sv
rtl/fetch_top.sv
dv/tb_fetch_top.sv

// File: rtl/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
	input  wire logic                               clk,
	input  wire logic                               rst,
	input  wire logic [icache_pkg::ADDR_W-1:0]      addr,
	input  wire logic                               valid,
	input  wire logic                               flush,
	input  wire logic                               ready_if_id,
	input  wire logic                               prog_we,
	input  wire logic [icache_pkg::MEM_ADDR_W-1:0]  prog_addr,
	input  wire logic [icache_pkg::LINE_W-1:0]      prog_data,
	output logic      [icache_pkg::INST_W-1:0]      inst,
	output logic                                    ready,
	output logic                                    hit
);

	import icache_pkg::*;

	logic [MEM_ADDR_W-1:0] line_addr;
	logic [LINE_W-1:0]     line_data;

	icache i_icache (
		.clk         (clk),
		.rst         (rst),
		.addr        (addr),
		.valid       (valid),
		.flush       (flush),
		.ready_if_id (ready_if_id),
		.line_data   (line_data),
		.inst        (inst),
		.ready       (ready),
		.hit         (hit),
		.line_addr   (line_addr)
	);

	inst_mem i_inst_mem (
		.clk       (clk),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.rd_addr   (line_addr),
		.rd_line   (line_data)
	);

	// the memory has no reset of its own, loading starts after reset
	assert property (@(posedge clk) !(prog_we && rst))
		else $error("fetch_top: memory load during reset");

endmodule

`default_nettype wire

// File: rtl/icache.sv
`timescale 1ns/1ns
`default_nettype none

module icache (
	input  wire logic                               clk,
	input  wire logic                               rst,
	input  wire logic [icache_pkg::ADDR_W-1:0]      addr,
	input  wire logic                               valid,
	input  wire logic                               flush,
	input  wire logic                               ready_if_id,
	input  wire logic [icache_pkg::LINE_W-1:0]      line_data,
	output logic      [icache_pkg::INST_W-1:0]      inst,
	output logic                                    ready,
	output logic                                    hit,
	output logic      [icache_pkg::MEM_ADDR_W-1:0]  line_addr
);

	import icache_pkg::*;

	logic [INDEX_W-1:0]    index;
	logic [TAG_W-1:0]      tag;
	logic [NUM_WAYS-1:0]   way_hit;
	logic [NUM_WAYS-1:0]   victim;
	logic [NUM_WAYS-1:0]   cen_n;
	logic                  wen_n;
	logic                  access;
	logic                  miss;
	logic [LINE_W-1:0]     dout [NUM_WAYS];

	logic [NUM_WAYS-1:0]   way_hit_r;
	logic [WORD_SEL_W-1:0] offset_r;
	logic [LINE_W-1:0]     line_r;
	logic [LINE_W-1:0]     sel_line;

	// --------------------------------------------------
	// lookup stage
	// --------------------------------------------------
	assign index     = addr[OFFSET_W +: INDEX_W];
	assign tag       = addr[ADDR_W-1 -: TAG_W];
	assign line_addr = addr[OFFSET_W +: MEM_ADDR_W];

	assign access = valid && ready_if_id;      // frozen under back-pressure
	assign miss   = access && (way_hit == '0);
	assign wen_n  = !miss;

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			cen_n[w] = !(access && (way_hit[w] || (miss && victim[w])));
		end
	end

	icache_tag_store i_tag_store (
		.clk      (clk),
		.rst      (rst),
		.index    (index),
		.tag      (tag),
		.fill     (miss),                      // fills even when flushed
		.fill_way (victim),
		.way_hit  (way_hit)
	);

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		icache_data_sram i_data_sram (
			.clk       (clk),
			.cen_n     (cen_n[w]),
			.wen_n     (wen_n),
			.sram_addr (index),
			.din       (line_data),
			.dout      (dout[w])
		);
	end

	// --------------------------------------------------
	// response registers and victim pointer
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			way_hit_r <= '0;
			ready     <= 1'b0;
			hit       <= 1'b0;
			victim    <= NUM_WAYS'(1);
		end else if (ready_if_id) begin
			if (flush) begin
				way_hit_r <= '0;
				ready     <= 1'b0;
				hit       <= 1'b0;
			end else begin
				way_hit_r <= valid ? way_hit : '0;
				ready     <= valid;
				hit       <= valid && (way_hit != '0);
				victim    <= {victim[NUM_WAYS-2:0], victim[NUM_WAYS-1]}; // rotate
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ready_if_id && !flush) begin
			offset_r <= addr[OFFSET_W-1:2];
			line_r   <= line_data;               // used on a miss
		end
	end

	// --------------------------------------------------
	// way and word select
	// --------------------------------------------------
	always_comb begin
		sel_line = line_r;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (way_hit_r[w]) begin
				sel_line = dout[w];
			end
		end
	end

	assign inst = sel_line[offset_r*INST_W +: INST_W];

	// a fill must always land in exactly one way
	assert property (@(posedge clk) disable iff (rst)
		$onehot(victim))
		else $error("icache: victim pointer not one-hot (%b)", victim);

endmodule

`default_nettype wire

// File: rtl/icache_data_sram.sv
`timescale 1ns/1ns
`default_nettype none

module icache_data_sram (
	input  wire logic                            clk,
	input  wire logic                            cen_n,
	input  wire logic                            wen_n,
	input  wire logic [icache_pkg::INDEX_W-1:0]  sram_addr,
	input  wire logic [icache_pkg::LINE_W-1:0]   din,
	output logic      [icache_pkg::LINE_W-1:0]   dout
);

	import icache_pkg::*;

	logic [LINE_W-1:0] mem [NUM_SETS];

	// --------------------------------------------------
	// single port, one access per edge
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!cen_n) begin
			if (!wen_n) begin
				mem[sram_addr] <= din;
				dout           <= din;      // write-through read
			end else begin
				dout           <= mem[sram_addr];
			end
		end
	end                                     // dout held while disabled

endmodule

`default_nettype wire

// File: rtl/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// --------------------------------------------------
	// fetch address and line geometry
	// --------------------------------------------------
	localparam int ADDR_W   = 32;              // fetch address
	localparam int LINE_W   = 128;             // one cache line
	localparam int INST_W   = 32;              // one instruction word

	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 64;

	// address split: tag [31:10], index [9:4], offset [3:0]
	localparam int OFFSET_W = 4;
	localparam int INDEX_W  = 6;
	localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

	// word select within a line, offset bits 3 to 2
	localparam int WORD_SEL_W     = OFFSET_W - 2;
	localparam int WORDS_PER_LINE = LINE_W / INST_W;

	// --------------------------------------------------
	// backing instruction memory
	// --------------------------------------------------
	localparam int MEM_LINES  = 1024;          // 16 KB
	localparam int MEM_ADDR_W = 10;            // line index from addr [13:4]

endpackage

`default_nettype wire

// File: rtl/icache_tag_store.sv
`timescale 1ns/1ns
`default_nettype none

module icache_tag_store (
	input  wire logic                             clk,
	input  wire logic                             rst,
	input  wire logic [icache_pkg::INDEX_W-1:0]   index,
	input  wire logic [icache_pkg::TAG_W-1:0]     tag,
	input  wire logic                             fill,
	input  wire logic [icache_pkg::NUM_WAYS-1:0]  fill_way,
	output logic      [icache_pkg::NUM_WAYS-1:0]  way_hit
);

	import icache_pkg::*;

	logic [TAG_W-1:0]    tags [NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0] vld  [NUM_WAYS];

	// --------------------------------------------------
	// valid bits
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				vld[w] <= '0;
			end
		end else if (fill) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (fill_way[w]) begin
					vld[w][index] <= 1'b1;
				end
			end
		end
	end

	// tag arrays
	always_ff @(posedge clk) begin
		if (fill) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (fill_way[w]) begin
					tags[w][index] <= tag;
				end
			end
		end
	end

	// --------------------------------------------------
	// lookup
	// --------------------------------------------------
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_hit[w] = vld[w][index] && (tags[w][index] == tag); // compare all ways
		end
	end

	// a tag is only ever filled into a way that missed, so no line can sit in two ways
	assert property (@(posedge clk) disable iff (rst)
		$onehot0(way_hit))
		else $error("icache_tag_store: more than one way hit at index %0d", index);

endmodule

`default_nettype wire

// File: rtl/inst_mem.sv
`timescale 1ns/1ns
`default_nettype none

module inst_mem (
	input  wire logic                               clk,
	input  wire logic                               prog_we,
	input  wire logic [icache_pkg::MEM_ADDR_W-1:0]  prog_addr,
	input  wire logic [icache_pkg::LINE_W-1:0]      prog_data,
	input  wire logic [icache_pkg::MEM_ADDR_W-1:0]  rd_addr,
	output logic      [icache_pkg::LINE_W-1:0]      rd_line
);

	import icache_pkg::*;

	logic [LINE_W-1:0] mem [MEM_LINES];

	// --------------------------------------------------
	// load port, one line per edge
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (prog_we) begin
			mem[prog_addr] <= prog_data;
		end
	end

	assign rd_line = mem[rd_addr];              // same-cycle line read

endmodule

`default_nettype wire
